//--- zx_core.f
+incdir+.
zx_pkg.sv
resetter.sv
zsignals.sv
zports.sv
pager.sv
zint.sv
zx_core.sv
tb_zx_core.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log &&
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_zx_core -f zx_core.f > build.log 2>&1 &&
./obj_dir/Vtb_zx_core > sim.log 2>&1

grep -q "TESTBENCH PASSED" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }

//--- tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// first failure ends the run
task automatic fail_run(input string msg);
	$display("%s", msg);
	$display("TESTBENCH FAILED");
	$fatal(1, "run stopped");
endtask

task automatic check_data(
	input string         name,
	input zx_pkg::data_t exp,
	input zx_pkg::data_t act
);
	if (act !== exp)
		fail_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
endtask

task automatic check_page(
	input string         name,
	input zx_pkg::page_t exp,
	input zx_pkg::page_t act
);
	if (act !== exp)
		fail_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
endtask

task automatic check_border(
	input string           name,
	input zx_pkg::border_t exp,
	input zx_pkg::border_t act
);
	if (act !== exp)
		fail_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
endtask

task automatic check_bit(
	input string name,
	input logic  exp,
	input logic  act
);
	if (act !== exp)
		fail_run($sformatf("** Error: %s expected %b actual %b", name, exp, act));
endtask

`endif

//--- tb_zx_core.sv
module tb_zx_core;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 100;
	localparam logic [31:0] SEED = 32'haa38;

	localparam int RST_CNT_SIZE = 3;
	localparam int FRAME_LEN    = 200;
	localparam int INT_LEN      = 16;

	// run length estimate for the watchdog
	localparam int BUS_CYCLES  = 12;
	localparam int BUS_OPS     = 18;
	localparam int TEST_FRAMES = 5;
	localparam int TEST_CYCLES = 5 + 4 * (2 ** RST_CNT_SIZE) + BUS_OPS * BUS_CYCLES
		+ TEST_FRAMES * FRAME_LEN;
	localparam int WATCHDOG_NS = (TEST_CYCLES + 20 * FRAME_LEN) * CLK_PERIOD;

	logic clk;
	logic rst_n;
	logic iorq_n;
	logic mreq_n;
	logic rd_n;
	logic wr_n;
	logic m1_n;
	zx_pkg::addr_t a;
	zx_pkg::data_t d_in;
	zx_pkg::data_t d_out;
	logic d_oe;
	logic int_n;
	logic res;
	logic csrom;
	logic romoe_n;
	logic rompg0_n;
	logic beep;
	zx_pkg::page_t ram_page;
	zx_pkg::border_t border;

	`include "tb_checks.svh"

	zx_core #(
		.RST_CNT_SIZE(RST_CNT_SIZE),
		.FRAME_LEN   (FRAME_LEN),
		.INT_LEN     (INT_LEN)
	) dut_i (
		.fclk    (clk),
		.rst_n   (rst_n),
		.iorq_n  (iorq_n),
		.mreq_n  (mreq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.m1_n    (m1_n),
		.a       (a),
		.d_in    (d_in),
		.d_out   (d_out),
		.d_oe    (d_oe),
		.int_n   (int_n),
		.res     (res),
		.csrom   (csrom),
		.romoe_n (romoe_n),
		.rompg0_n(rompg0_n),
		.ram_page(ram_page),
		.border  (border),
		.beep    (beep)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("timeout: the tests did not finish in the expected time");
	end

	////////////////////////////////////////////////////////////
	// z80 bus cycles
	////////////////////////////////////////////////////////////

	task automatic io_write(input zx_pkg::addr_t addr, input zx_pkg::data_t data);
		@(posedge clk);
		a      <= addr;
		d_in   <= data;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		repeat (8) @(posedge clk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
		repeat (4) @(posedge clk);
	endtask

	// data reads as ff when nothing drives the bus
	task automatic io_read(
		input  zx_pkg::addr_t addr,
		output zx_pkg::data_t data,
		output logic          oe
	);
		@(posedge clk);
		a      <= addr;
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		repeat (7) @(posedge clk);
		@(negedge clk);
		oe   = d_oe;
		data = d_oe ? d_out : 8'hff;
		@(posedge clk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		repeat (4) @(posedge clk);
	endtask

	task automatic mem_read(
		input  zx_pkg::addr_t addr,
		output zx_pkg::page_t pg,
		output logic          oe_n,
		output logic          cs
	);
		@(posedge clk);
		a      <= addr;
		mreq_n <= 1'b0;
		rd_n   <= 1'b0;
		repeat (7) @(posedge clk);
		@(negedge clk);
		pg   = ram_page;
		oe_n = romoe_n;
		cs   = csrom;
		@(posedge clk);
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		repeat (4) @(posedge clk);
	endtask

	task automatic int_ack();
		@(posedge clk);
		iorq_n <= 1'b0;
		m1_n   <= 1'b0;
		repeat (8) @(posedge clk);
		iorq_n <= 1'b1;
		m1_n   <= 1'b1;
		repeat (4) @(posedge clk);
	endtask

	task automatic wait_int_fall();
		int n;
		n = 0;
		while (int_n !== 1'b0 && n <= FRAME_LEN + 2 * BUS_CYCLES) begin
			@(negedge clk);
			n++;
		end
		if (int_n !== 1'b0)
			fail_run("int_n did not fall within one frame after interrupts were enabled");
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic reset_defaults();
		zx_pkg::data_t val;
		logic oe;
		@(negedge clk);
		check_bit("reset int_n", 1'b1, int_n);
		check_bit("reset romoe_n", 1'b1, romoe_n);
		check_bit("reset csrom", 1'b0, csrom);
		check_bit("reset rompg0_n", 1'b1, rompg0_n);
		check_bit("reset d_oe", 1'b0, d_oe);
		check_border("reset border", 3'd0, border);
		check_bit("reset beep", 1'b0, beep);
		io_read(zx_pkg::PORT_SYSCONF, val, oe);
		check_bit("sysconf read oe", 1'b1, oe);
		check_data("reset sysconf", 8'h00, val);
		io_read(zx_pkg::PORT_PAGEMIR, val, oe);
		check_bit("pagemir read oe", 1'b1, oe);
		check_data("reset pagemir", 8'h00, val);
		@(negedge clk);
		check_bit("d_oe after read", 1'b0, d_oe);
	endtask

	task automatic fe_port();
		zx_pkg::data_t val;
		zx_pkg::data_t rd_val;
		logic oe;
		val = zx_pkg::data_t'($urandom);
		io_write(16'h00fe, val);
		@(negedge clk);
		check_border("fe border", val[2:0], border);
		check_bit("fe beep", val[4], beep);
		// odd port address must not reach #FE
		io_write(16'h00ff, ~val);
		@(negedge clk);
		check_border("odd port border", val[2:0], border);
		check_bit("odd port beep", val[4], beep);
		io_read(16'h00fe, rd_val, oe);
		check_bit("fe read oe", 1'b0, oe);
	endtask

	task automatic memory_map();
		zx_pkg::data_t val;
		zx_pkg::page_t pg;
		logic oe_n;
		logic cs;
		val = zx_pkg::data_t'($urandom);
		val[5] = 1'b0;
		io_write(16'h7ffd, val);
		mem_read(16'hc000, pg, oe_n, cs);
		check_page("window 3 page", {5'd0, val[2:0]}, pg);
		check_bit("window 3 romoe_n", 1'b1, oe_n);
		mem_read(16'h0000, pg, oe_n, cs);
		check_page("window 0 page", {7'd0, val[4]}, pg);
		check_bit("window 0 romoe_n", 1'b0, oe_n);
		check_bit("window 0 csrom", 1'b1, cs);
		check_bit("rompg0_n", ~val[4], rompg0_n);
		mem_read(16'h4000, pg, oe_n, cs);
		check_page("window 1 page", 8'd5, pg);
		check_bit("window 1 csrom", 1'b0, cs);
		mem_read(16'h8000, pg, oe_n, cs);
		check_page("window 2 page", 8'd2, pg);
	endtask

	task automatic page_lock();
		zx_pkg::data_t lock_val;
		zx_pkg::data_t other;
		zx_pkg::data_t new_val;
		zx_pkg::data_t val;
		logic oe;
		lock_val = zx_pkg::data_t'($urandom);
		lock_val[5] = 1'b1;
		other = ~lock_val;
		new_val = zx_pkg::data_t'($urandom);
		new_val[5] = 1'b0;
		io_write(16'h7ffd, lock_val);
		io_read(zx_pkg::PORT_PAGEMIR, val, oe);
		check_data("locked value", lock_val, val);
		io_write(16'h7ffd, other);
		io_read(zx_pkg::PORT_PAGEMIR, val, oe);
		check_data("write while locked", lock_val, val);
		io_write(zx_pkg::PORT_PAGEMIR, new_val);
		io_read(zx_pkg::PORT_PAGEMIR, val, oe);
		check_data("mirror unlock", new_val, val);
	endtask

	task automatic frame_interrupt();
		int cnt;
		repeat (3 * FRAME_LEN) begin
			@(negedge clk);
			check_bit("int disabled", 1'b1, int_n);
		end
		io_write(zx_pkg::PORT_SYSCONF, 8'h01);
		@(negedge clk);
		wait_int_fall();
		cnt = 0;
		while (int_n === 1'b0 && cnt <= 2 * INT_LEN) begin
			cnt++;
			@(negedge clk);
		end
		check_data("int pulse length", zx_pkg::data_t'(INT_LEN), zx_pkg::data_t'(cnt));
		// the next pulse is cut short by the acknowledge
		wait_int_fall();
		fork
			int_ack();
			begin
				cnt = 0;
				while (int_n === 1'b0 && cnt < INT_LEN - 1) begin
					@(negedge clk);
					cnt++;
				end
				check_bit("int_ack clears int_n", 1'b1, int_n);
			end
		join
	endtask

	initial begin
		rst_n  <= 1'b0;
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
		a      <= 16'hffff;
		d_in   <= 8'h00;
		void'($urandom(SEED));
		repeat (5) @(posedge clk);
		check_bit("res during reset", 1'b1, res);
		rst_n <= 1'b1;
		repeat (2 ** RST_CNT_SIZE + 4) @(posedge clk);
		check_bit("res after release", 1'b0, res);
		reset_defaults();
		fe_port();
		memory_map();
		page_lock();
		frame_interrupt();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- zx_core.sv
module zx_core #(
	parameter int RST_CNT_SIZE = 6,
	parameter int FRAME_LEN    = 71680,
	parameter int INT_LEN      = 32
) (
	input  logic            fclk,
	input  logic            rst_n,

	// z80
	input  logic            iorq_n,
	input  logic            mreq_n,
	input  logic            rd_n,
	input  logic            wr_n,
	input  logic            m1_n,
	input  zx_pkg::addr_t   a,
	input  zx_pkg::data_t   d_in,
	output zx_pkg::data_t   d_out,
	output logic            d_oe,
	output logic            int_n,
	output logic            res,

	// rom and memory
	output logic            csrom,
	output logic            romoe_n,
	output logic            rompg0_n,
	output zx_pkg::page_t   ram_page,

	// board
	output zx_pkg::border_t border,
	output logic            beep
);

	logic core_rst_n;

	zx_pkg::addr_t a_s;
	logic iord;
	logic memrd;
	logic iowr_s;
	logic intack_s;

	zx_pkg::data_t p7ffd;
	zx_pkg::data_t sysconf;

	////////////////////////////////////////////////////////////
	// reset
	////////////////////////////////////////////////////////////

	resetter #(
		.RST_CNT_SIZE(RST_CNT_SIZE)
	) myrst (
		.clk      (fclk),
		.rst_n    (rst_n),
		.rst_out_n(core_rst_n)
	);

	assign res = ~core_rst_n;

	////////////////////////////////////////////////////////////
	// cpu bus
	////////////////////////////////////////////////////////////

	zsignals zsignals (
		.fclk    (fclk),
		.rst_n   (core_rst_n),
		.iorq_n  (iorq_n),
		.mreq_n  (mreq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.m1_n    (m1_n),
		.a       (a),
		.a_s     (a_s),
		.iord    (iord),
		.memrd   (memrd),
		.iowr_s  (iowr_s),
		.intack_s(intack_s)
	);

	zports zports (
		.fclk   (fclk),
		.rst_n  (core_rst_n),
		.a      (a_s),
		.d_in   (d_in),
		.iowr_s (iowr_s),
		.iord   (iord),
		.d_out  (d_out),
		.d_oe   (d_oe),
		.border (border),
		.beep   (beep),
		.p7ffd  (p7ffd),
		.sysconf(sysconf)
	);

	// memory map
	pager pager (
		.a       (a_s),
		.p7ffd   (p7ffd),
		.memrd   (memrd),
		.page    (ram_page),
		.csrom   (csrom),
		.romoe_n (romoe_n),
		.rompg0_n(rompg0_n)
	);

	zint #(
		.FRAME_LEN(FRAME_LEN),
		.INT_LEN  (INT_LEN)
	) zint (
		.fclk    (fclk),
		.rst_n   (core_rst_n),
		.sysconf (sysconf),
		.intack_s(intack_s),
		.int_n   (int_n)
	);

endmodule

//--- zint.sv
module zint #(
	parameter int FRAME_LEN = 71680,
	parameter int INT_LEN   = 32
) (
	input  logic          fclk,
	input  logic          rst_n,
	input  zx_pkg::data_t sysconf,
	input  logic          intack_s,
	output logic          int_n
);

	localparam int FRM_W = $clog2(FRAME_LEN);
	localparam int INT_W = $clog2(INT_LEN + 1);

	localparam logic [FRM_W-1:0] FRM_LAST = FRM_W'(FRAME_LEN - 1);
	localparam logic [INT_W-1:0] INT_LAST = INT_W'(INT_LEN - 1);

	logic [FRM_W-1:0] frm_cnt;
	logic [INT_W-1:0] int_cnt;
	logic frm_wrap;

	zx_pkg::int_state_t int_state;

	////////////////////////////////////////////////////////////
	// frame timer
	////////////////////////////////////////////////////////////

	assign frm_wrap = (frm_cnt == FRM_LAST);

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n)
			frm_cnt <= '0;
		else if (frm_wrap)
			frm_cnt <= '0;
		else
			frm_cnt <= frm_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// int pulse
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			int_state <= zx_pkg::INT_IDLE;
			int_cnt   <= '0;
		end else begin
			unique case (int_state)
				zx_pkg::INT_IDLE: begin
					int_cnt <= '0;
					if (frm_wrap && sysconf[zx_pkg::SYSCONF_INTEN_BIT])
						int_state <= zx_pkg::INT_ACTIVE;
				end
				zx_pkg::INT_ACTIVE: begin
					int_cnt <= int_cnt + 1'b1;
					// timeout or acknowledge from the cpu
					if (int_cnt == INT_LAST || intack_s)
						int_state <= zx_pkg::INT_IDLE;
				end
				default: int_state <= zx_pkg::INT_IDLE;
			endcase
		end
	end

	assign int_n = (int_state != zx_pkg::INT_ACTIVE);

endmodule

//--- pager.sv
module pager (
	input  zx_pkg::addr_t a,
	input  zx_pkg::data_t p7ffd,
	input  logic          memrd,
	output zx_pkg::page_t page,
	output logic          csrom,
	output logic          romoe_n,
	output logic          rompg0_n
);

	logic romnram;
	logic rom_pg;
	logic [2:0] ram_pg;

	assign rom_pg = p7ffd[zx_pkg::P7FFD_ROM_BIT];
	assign ram_pg = p7ffd[zx_pkg::P7FFD_RAM_MSB:zx_pkg::P7FFD_RAM_LSB];

	// window select by the top two address bits
	always_comb begin
		romnram = 1'b0;
		unique case (a[15:14])
			2'b00: begin
				romnram = 1'b1;
				page    = {7'd0, rom_pg};
			end
			2'b01:   page = zx_pkg::WIN1_PAGE;
			2'b10:   page = zx_pkg::WIN2_PAGE;
			default: page = {5'd0, ram_pg};
		endcase
	end

	// rom chip
	assign csrom    = romnram;
	assign romoe_n  = ~(memrd & romnram);
	assign rompg0_n = ~rom_pg;

endmodule

//--- zports.sv
module zports (
	input  logic            fclk,
	input  logic            rst_n,
	input  zx_pkg::addr_t   a,
	input  zx_pkg::data_t   d_in,
	input  logic            iowr_s,
	input  logic            iord,
	output zx_pkg::data_t   d_out,
	output logic            d_oe,
	output zx_pkg::border_t border,
	output logic            beep,
	output zx_pkg::data_t   p7ffd,
	output zx_pkg::data_t   sysconf
);

	logic sel_fe;
	logic sel_7ffd;
	logic sel_sysconf;
	logic sel_pagemir;

	logic p7ffd_locked;

	////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////

	// classic ports use partial decoding
	assign sel_fe   = ~a[0];
	assign sel_7ffd = ~a[15] & ~a[1];

	assign sel_sysconf = (a == zx_pkg::PORT_SYSCONF);
	assign sel_pagemir = (a == zx_pkg::PORT_PAGEMIR);

	assign p7ffd_locked = p7ffd[zx_pkg::P7FFD_LOCK_BIT];

	////////////////////////////////////////////////////////////
	// write registers
	////////////////////////////////////////////////////////////

	// border and beeper
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			border <= '0;
			beep   <= 1'b0;
		end else if (iowr_s && sel_fe) begin
			border <= d_in[2:0];
			beep   <= d_in[zx_pkg::FE_BEEP_BIT];
		end
	end

	// the mirror port bypasses the paging lock
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			p7ffd <= '0;
		end else if (iowr_s) begin
			if (sel_pagemir) begin
				p7ffd <= d_in;
			end else if (sel_7ffd && !p7ffd_locked) begin
				p7ffd <= d_in;
			end
		end
	end

	// system config
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			sysconf <= '0;
		end else if (iowr_s && sel_sysconf) begin
			sysconf <= d_in;
		end
	end

	////////////////////////////////////////////////////////////
	// read back
	////////////////////////////////////////////////////////////

	always_comb begin
		d_oe  = 1'b0;
		d_out = '0;
		if (iord) begin
			if (sel_pagemir) begin
				d_oe  = 1'b1;
				d_out = p7ffd;
			end else if (sel_sysconf) begin
				d_oe  = 1'b1;
				d_out = sysconf;
			end
		end
	end

endmodule

//--- zsignals.sv
module zsignals (
	input  logic          fclk,
	input  logic          rst_n,
	input  logic          iorq_n,
	input  logic          mreq_n,
	input  logic          rd_n,
	input  logic          wr_n,
	input  logic          m1_n,
	input  zx_pkg::addr_t a,
	output zx_pkg::addr_t a_s,
	output logic          iord,
	output logic          memrd,
	output logic          iowr_s,
	output logic          intack_s
);

	logic [4:0] strb_s1;
	logic [4:0] strb_s2;
	zx_pkg::addr_t a_s1;

	logic iorq;
	logic mreq;
	logic rd;
	logic wr;
	logic m1;

	logic iowr;
	logic intack;
	logic [1:0] cond_d;

	////////////////////////////////////////////////////////////
	// two flop synchronizers
	////////////////////////////////////////////////////////////

	// strobes idle high
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			strb_s1 <= '1;
			strb_s2 <= '1;
		end else begin
			strb_s1 <= {iorq_n, mreq_n, rd_n, wr_n, m1_n};
			strb_s2 <= strb_s1;
		end
	end

	// address follows the same two stages
	always_ff @(posedge fclk) begin
		a_s1 <= a;
		a_s  <= a_s1;
	end

	assign iorq = ~strb_s2[4];
	assign mreq = ~strb_s2[3];
	assign rd   = ~strb_s2[2];
	assign wr   = ~strb_s2[1];
	assign m1   = ~strb_s2[0];

	////////////////////////////////////////////////////////////
	// bus cycle decode
	////////////////////////////////////////////////////////////

	assign iord   = iorq & rd & ~m1;
	assign iowr   = iorq & wr & ~m1;
	assign intack = iorq & m1;
	assign memrd  = mreq & rd;

	// strobe fires once and rearms when the condition drops
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			cond_d   <= '0;
			iowr_s   <= 1'b0;
			intack_s <= 1'b0;
		end else begin
			cond_d   <= {iowr, intack};
			iowr_s   <= iowr & ~cond_d[1];
			intack_s <= intack & ~cond_d[0];
		end
	end

endmodule

//--- resetter.sv
module resetter #(
	parameter int RST_CNT_SIZE = 6
) (
	input  logic clk,
	input  logic rst_n,
	output logic rst_out_n
);

	logic [RST_CNT_SIZE-1:0] rst_cnt;

	// assert at once and release after the counter fills up
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rst_cnt   <= '0;
			rst_out_n <= 1'b0;
		end else if (rst_cnt != '1) begin
			rst_cnt   <= rst_cnt + 1'b1;
			rst_out_n <= 1'b0;
		end else begin
			rst_out_n <= 1'b1;
		end
	end

endmodule

//--- zx_pkg.sv
package zx_pkg;

	////////////////////////////////////////////////////////////
	// bus widths
	////////////////////////////////////////////////////////////

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [7:0]  page_t;
	typedef logic [2:0]  border_t;

	// frame interrupt generator
	typedef enum logic {
		INT_IDLE,
		INT_ACTIVE
	} int_state_t;

	////////////////////////////////////////////////////////////
	// ports fully decoded on 16 bits
	////////////////////////////////////////////////////////////

	localparam addr_t PORT_SYSCONF = 16'h20AF;
	localparam addr_t PORT_PAGEMIR = 16'h21AF;

	// #7FFD fields
	localparam int P7FFD_RAM_LSB  = 0;
	localparam int P7FFD_RAM_MSB  = 2;
	localparam int P7FFD_ROM_BIT  = 4;
	localparam int P7FFD_LOCK_BIT = 5;

	// #FE fields
	localparam int FE_BEEP_BIT = 4;

	// sysconf fields
	localparam int SYSCONF_INTEN_BIT = 0;

	// fixed ram pages of the middle windows
	localparam page_t WIN1_PAGE = 8'd5;
	localparam page_t WIN2_PAGE = 8'd2;

endpackage
